// ==== Bender.yml ====
package:
  name: issueSubsystem

sources:
  # RTL in compile order
  - hdl/issuePkg.sv
  - hdl/issueQueue.sv
  - hdl/wbSlotTimer.sv
  - hdl/mulCtrl.sv
  - hdl/mulDatapath.sv
  - hdl/aluWriteback.sv
  - hdl/issueSubsystem.sv

  # Testbench
  - target: test
    include_dirs:
      - test
    files:
      - test/issueTb.sv

// ==== hdl/aluWriteback.sv ====
`timescale 1ns/10ps

module aluWriteback (
    input  logic              clk,
    input  logic              rst,
    input  logic              issValid,
    input  issuePkg::FuncUnit issFu,
    input  issuePkg::AluOp    issOp,
    input  issuePkg::Tag      issTag,
    input  issuePkg::Data     issDataA,
    input  issuePkg::Data     issDataB,
    input  logic              mulDone,
    input  issuePkg::Tag      mulTagOut,
    input  issuePkg::Data     mulResult,
    output logic              wbValid,
    output issuePkg::Tag      wbTag,
    output issuePkg::Data     wbData
);

    issuePkg::Data aluResult;
    logic          aluIssue;

    assign aluIssue = issValid && issFu == issuePkg::FU_ALU;

    always_comb begin
        case (issOp)
            issuePkg::ADD: aluResult = issDataA + issDataB;
            issuePkg::SUB: aluResult = issDataA - issDataB;
            issuePkg::AND: aluResult = issDataA & issDataB;
            issuePkg::XOR: aluResult = issDataA ^ issDataB;
            default:       aluResult = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wbValid <= 1'b0;
        end else begin
            wbValid <= aluIssue || mulDone;
        end
    end

    // Slot timer keeps the two sources apart
    always_ff @(posedge clk) begin
        if (aluIssue) begin
            wbTag <= issTag;
            wbData <= aluResult;
        end else if (mulDone) begin
            wbTag <= mulTagOut;
            wbData <= mulResult;
        end
    end

    singleWbPort: assert property (@(posedge clk) disable iff (rst)
        !(aluIssue && mulDone))
        else $error("ALU and multiplier results compete for the writeback port");

endmodule

// ==== hdl/issuePkg.sv ====
package issuePkg;

    // Widths of the values that travel through the issue stage
    localparam int TAG_BITS = 5;
    localparam int SQN_BITS = 6;
    localparam int DATA_BITS = 16;

    // Issue queue geometry
    localparam int IQ_SIZE = 8;
    localparam int IQ_CNT_BITS = 4;
    localparam int IQ_IDX_BITS = 3;

    // Multiplier sequencing
    localparam int MUL_STEPS = DATA_BITS;
    localparam int MUL_CNT_BITS = 4;
    // Load cycle, one cycle per step, done cycle
    localparam int MUL_LATENCY = MUL_STEPS + 2;

    // Writeback slot timer
    localparam int WB_SLOT_BITS = MUL_LATENCY;
    // Slot bit set on reserve so that it reaches bit 0 in the last ALU select cycle
    localparam int WB_RESERVE_BIT = MUL_LATENCY - 2;

    typedef logic [TAG_BITS-1:0] Tag;
    typedef logic [SQN_BITS-1:0] SqN;
    typedef logic [DATA_BITS-1:0] Data;
    typedef logic [IQ_CNT_BITS-1:0] IqCnt;
    typedef logic [IQ_IDX_BITS-1:0] IqIdx;
    typedef logic [MUL_CNT_BITS-1:0] MulCnt;

    typedef enum logic {
        FU_ALU,
        FU_MUL
    } FuncUnit;

    typedef enum logic [1:0] {
        ADD,
        SUB,
        AND,
        XOR
    } AluOp;

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DONE
    } MulState;

endpackage

// ==== hdl/issueQueue.sv ====
`timescale 1ns/10ps

module issueQueue (
    input  logic              clk,
    input  logic              rst,
    input  logic              dispValid,
    input  issuePkg::FuncUnit dispFu,
    input  issuePkg::AluOp    dispOp,
    input  issuePkg::SqN      dispSqN,
    input  issuePkg::Tag      dispTagDst,
    input  issuePkg::Tag      dispTagA,
    input  issuePkg::Tag      dispTagB,
    input  logic              dispAvailA,
    input  logic              dispAvailB,
    input  issuePkg::Data     dispDataA,
    input  issuePkg::Data     dispDataB,
    input  logic              extWakeValid,
    input  issuePkg::Tag      extWakeTag,
    input  logic              wbValid,
    input  issuePkg::Tag      wbTag,
    input  logic              flushValid,
    input  issuePkg::SqN      flushSqN,
    input  logic              mulBusy,
    input  logic              slotTaken,
    output logic              full,
    output logic              issValid,
    output issuePkg::FuncUnit issFu,
    output issuePkg::AluOp    issOp,
    output issuePkg::Tag      issTag,
    output issuePkg::Data     issDataA,
    output issuePkg::Data     issDataB,
    output logic              mulReserve
);

    issuePkg::FuncUnit entFu [issuePkg::IQ_SIZE];
    issuePkg::AluOp    entOp [issuePkg::IQ_SIZE];
    issuePkg::SqN      entSqN [issuePkg::IQ_SIZE];
    issuePkg::Tag      entTagDst [issuePkg::IQ_SIZE];
    issuePkg::Tag      entTagA [issuePkg::IQ_SIZE];
    issuePkg::Tag      entTagB [issuePkg::IQ_SIZE];
    issuePkg::Data     entDataA [issuePkg::IQ_SIZE];
    issuePkg::Data     entDataB [issuePkg::IQ_SIZE];

    logic [issuePkg::IQ_SIZE-1:0] availA;
    logic [issuePkg::IQ_SIZE-1:0] availB;
    logic [issuePkg::IQ_SIZE-1:0] wakeA;
    logic [issuePkg::IQ_SIZE-1:0] wakeB;
    logic [issuePkg::IQ_SIZE-1:0] younger;

    issuePkg::IqCnt count;
    issuePkg::IqCnt keepCount;
    issuePkg::IqCnt insPos;
    issuePkg::IqCnt nextCount;
    issuePkg::IqIdx selIdx;
    logic           selValid;
    logic           issueFire;
    logic           dispWakeA;
    logic           dispWakeB;

    // Tag match against writeback bus and external wake, plus flush age compare
    always_comb begin
        for (int i = 0; i < issuePkg::IQ_SIZE; i++) begin
            wakeA[i] = (wbValid && wbTag == entTagA[i])
                || (extWakeValid && extWakeTag == entTagA[i]);
            wakeB[i] = (wbValid && wbTag == entTagB[i])
                || (extWakeValid && extWakeTag == entTagB[i]);
            younger[i] = flushValid
                && ($signed(issuePkg::SqN'(entSqN[i] - flushSqN)) > 0);
        end
    end

    assign dispWakeA = (wbValid && wbTag == dispTagA) || (extWakeValid && extWakeTag == dispTagA);
    assign dispWakeB = (wbValid && wbTag == dispTagB) || (extWakeValid && extWakeTag == dispTagB);

    // Oldest ready entry wins; entry 0 is the oldest
    always_comb begin
        selValid = 1'b0;
        selIdx = '0;
        keepCount = '0;
        for (int i = 0; i < issuePkg::IQ_SIZE; i++) begin
            if (i < count) begin
                if (!selValid && availA[i] && availB[i]
                        && !(entFu[i] == issuePkg::FU_MUL && mulBusy)
                        && !(entFu[i] == issuePkg::FU_ALU && slotTaken)) begin
                    selValid = 1'b1;
                    selIdx = issuePkg::IqIdx'(i);
                end
                // Surviving entries form a prefix since the queue is age ordered
                if (!younger[i]) begin
                    keepCount = issuePkg::IqCnt'(i + 1);
                end
            end
        end
    end

    assign issueFire = selValid && !younger[selIdx];
    assign mulReserve = issueFire && entFu[selIdx] == issuePkg::FU_MUL;
    assign insPos = keepCount - issuePkg::IqCnt'(issueFire);
    assign nextCount = insPos + issuePkg::IqCnt'(dispValid);
    assign full = count == issuePkg::IqCnt'(issuePkg::IQ_SIZE);

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
            issValid <= 1'b0;
        end else begin
            count <= nextCount;
            issValid <= issueFire;
        end
    end

    always_ff @(posedge clk) begin
        issFu <= entFu[selIdx];
        issOp <= entOp[selIdx];
        issTag <= entTagDst[selIdx];
        issDataA <= entDataA[selIdx];
        issDataB <= entDataB[selIdx];

        for (int j = 0; j < issuePkg::IQ_SIZE; j++) begin
            availA[j] <= availA[j] | wakeA[j];
            availB[j] <= availB[j] | wakeB[j];
        end

        // Collapse everything behind the issued entry by one slot
        if (issueFire) begin
            for (int j = 0; j < issuePkg::IQ_SIZE - 1; j++) begin
                if (j >= selIdx) begin
                    entFu[j] <= entFu[j+1];
                    entOp[j] <= entOp[j+1];
                    entSqN[j] <= entSqN[j+1];
                    entTagDst[j] <= entTagDst[j+1];
                    entTagA[j] <= entTagA[j+1];
                    entTagB[j] <= entTagB[j+1];
                    entDataA[j] <= entDataA[j+1];
                    entDataB[j] <= entDataB[j+1];
                    availA[j] <= availA[j+1] | wakeA[j+1];
                    availB[j] <= availB[j+1] | wakeB[j+1];
                end
            end
        end

        if (dispValid) begin
            entFu[insPos[issuePkg::IQ_IDX_BITS-1:0]] <= dispFu;
            entOp[insPos[issuePkg::IQ_IDX_BITS-1:0]] <= dispOp;
            entSqN[insPos[issuePkg::IQ_IDX_BITS-1:0]] <= dispSqN;
            entTagDst[insPos[issuePkg::IQ_IDX_BITS-1:0]] <= dispTagDst;
            entTagA[insPos[issuePkg::IQ_IDX_BITS-1:0]] <= dispTagA;
            entTagB[insPos[issuePkg::IQ_IDX_BITS-1:0]] <= dispTagB;
            entDataA[insPos[issuePkg::IQ_IDX_BITS-1:0]] <= dispDataA;
            entDataB[insPos[issuePkg::IQ_IDX_BITS-1:0]] <= dispDataB;
            availA[insPos[issuePkg::IQ_IDX_BITS-1:0]] <= dispAvailA | dispWakeA;
            availB[insPos[issuePkg::IQ_IDX_BITS-1:0]] <= dispAvailB | dispWakeB;
        end
    end

    countBound: assert property (@(posedge clk) disable iff (rst)
        count <= issuePkg::IqCnt'(issuePkg::IQ_SIZE))
        else $error("issue queue count above capacity");

    noDispWhenFull: assert property (@(posedge clk) disable iff (rst)
        dispValid |-> !full)
        else $error("dispatch while issue queue is full");

endmodule

// ==== hdl/issueSubsystem.sv ====
`timescale 1ns/10ps

module issueSubsystem (
    input  logic              clk,
    input  logic              rst,
    input  logic              dispValid,
    input  issuePkg::FuncUnit dispFu,
    input  issuePkg::AluOp    dispOp,
    input  issuePkg::SqN      dispSqN,
    input  issuePkg::Tag      dispTagDst,
    input  issuePkg::Tag      dispTagA,
    input  issuePkg::Tag      dispTagB,
    input  logic              dispAvailA,
    input  logic              dispAvailB,
    input  issuePkg::Data     dispDataA,
    input  issuePkg::Data     dispDataB,
    input  logic              extWakeValid,
    input  issuePkg::Tag      extWakeTag,
    input  logic              flushValid,
    input  issuePkg::SqN      flushSqN,
    output logic              full,
    output logic              wbValid,
    output issuePkg::Tag      wbTag,
    output issuePkg::Data     wbData
);

    logic              issValid;
    issuePkg::FuncUnit issFu;
    issuePkg::AluOp    issOp;
    issuePkg::Tag      issTag;
    issuePkg::Data     issDataA;
    issuePkg::Data     issDataB;
    logic              mulReserve;
    logic              slotTaken;
    logic              mulBusy;
    logic              mulLoad;
    logic              mulStep;
    logic              mulDone;
    issuePkg::Tag      mulTagOut;
    issuePkg::Data     mulResult;

    issueQueue i_issueQueue (
        .clk(clk),
        .rst(rst),
        .dispValid(dispValid),
        .dispFu(dispFu),
        .dispOp(dispOp),
        .dispSqN(dispSqN),
        .dispTagDst(dispTagDst),
        .dispTagA(dispTagA),
        .dispTagB(dispTagB),
        .dispAvailA(dispAvailA),
        .dispAvailB(dispAvailB),
        .dispDataA(dispDataA),
        .dispDataB(dispDataB),
        .extWakeValid(extWakeValid),
        .extWakeTag(extWakeTag),
        .wbValid(wbValid),
        .wbTag(wbTag),
        .flushValid(flushValid),
        .flushSqN(flushSqN),
        .mulBusy(mulBusy),
        .slotTaken(slotTaken),
        .full(full),
        .issValid(issValid),
        .issFu(issFu),
        .issOp(issOp),
        .issTag(issTag),
        .issDataA(issDataA),
        .issDataB(issDataB),
        .mulReserve(mulReserve)
    );

    wbSlotTimer i_wbSlotTimer (
        .clk(clk),
        .rst(rst),
        .mulReserve(mulReserve),
        .slotTaken(slotTaken)
    );

    mulCtrl i_mulCtrl (
        .clk(clk),
        .rst(rst),
        .issValid(issValid),
        .issFu(issFu),
        .issTag(issTag),
        .mulBusy(mulBusy),
        .mulLoad(mulLoad),
        .mulStep(mulStep),
        .mulDone(mulDone),
        .mulTagOut(mulTagOut)
    );

    mulDatapath i_mulDatapath (
        .clk(clk),
        .rst(rst),
        .mulLoad(mulLoad),
        .mulStep(mulStep),
        .issDataA(issDataA),
        .issDataB(issDataB),
        .mulResult(mulResult)
    );

    aluWriteback i_aluWriteback (
        .clk(clk),
        .rst(rst),
        .issValid(issValid),
        .issFu(issFu),
        .issOp(issOp),
        .issTag(issTag),
        .issDataA(issDataA),
        .issDataB(issDataB),
        .mulDone(mulDone),
        .mulTagOut(mulTagOut),
        .mulResult(mulResult),
        .wbValid(wbValid),
        .wbTag(wbTag),
        .wbData(wbData)
    );

endmodule

// ==== hdl/mulCtrl.sv ====
`timescale 1ns/10ps

module mulCtrl (
    input  logic              clk,
    input  logic              rst,
    input  logic              issValid,
    input  issuePkg::FuncUnit issFu,
    input  issuePkg::Tag      issTag,
    output logic              mulBusy,
    output logic              mulLoad,
    output logic              mulStep,
    output logic              mulDone,
    output issuePkg::Tag      mulTagOut
);

    issuePkg::MulState state;
    issuePkg::MulCnt   stepCnt;

    assign mulLoad = state == issuePkg::IDLE && issValid && issFu == issuePkg::FU_MUL;
    assign mulStep = state == issuePkg::RUN;
    assign mulDone = state == issuePkg::DONE;
    // Busy already while the multiply sits in the issue register
    assign mulBusy = state != issuePkg::IDLE || mulLoad;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= issuePkg::IDLE;
            stepCnt <= '0;
        end else begin
            case (state)
                issuePkg::IDLE: begin
                    stepCnt <= '0;
                    if (mulLoad) begin
                        state <= issuePkg::RUN;
                    end
                end
                issuePkg::RUN: begin
                    stepCnt <= stepCnt + 1'b1;
                    if (stepCnt == issuePkg::MulCnt'(issuePkg::MUL_STEPS - 1)) begin
                        state <= issuePkg::DONE;
                    end
                end
                issuePkg::DONE: begin
                    state <= issuePkg::IDLE;
                end
                default: begin
                    state <= issuePkg::IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (mulLoad) begin
            mulTagOut <= issTag;
        end
    end

    mulOnlyWhenIdle: assert property (@(posedge clk) disable iff (rst)
        (issValid && issFu == issuePkg::FU_MUL) |-> state == issuePkg::IDLE)
        else $error("multiply issued while multiplier not idle");

endmodule

// ==== hdl/mulDatapath.sv ====
`timescale 1ns/10ps

module mulDatapath (
    input  logic          clk,
    input  logic          rst,
    input  logic          mulLoad,
    input  logic          mulStep,
    input  issuePkg::Data issDataA,
    input  issuePkg::Data issDataB,
    output issuePkg::Data mulResult
);

    // Only the low product bits are kept, so the multiplicand never needs more width
    issuePkg::Data multiplicand;
    issuePkg::Data multiplier;
    issuePkg::Data acc;

    always_ff @(posedge clk) begin
        if (mulLoad) begin
            multiplicand <= issDataA;
            multiplier <= issDataB;
        end else if (mulStep) begin
            multiplicand <= multiplicand << 1;
            multiplier <= multiplier >> 1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            acc <= '0;
        end else if (mulLoad) begin
            acc <= '0;
        end else if (mulStep && multiplier[0]) begin
            acc <= acc + multiplicand;
        end
    end

    assign mulResult = acc;

endmodule

// ==== hdl/wbSlotTimer.sv ====
`timescale 1ns/10ps

module wbSlotTimer (
    input  logic clk,
    input  logic rst,
    input  logic mulReserve,
    output logic slotTaken
);

    // One bit per future cycle, bit 0 is the current ALU select cycle
    logic [issuePkg::WB_SLOT_BITS-1:0] slots;

    always_ff @(posedge clk) begin
        if (rst) begin
            slots <= '0;
        end else begin
            slots <= slots >> 1;
            // Multiply enters the issue register on this edge
            if (mulReserve) begin
                slots[issuePkg::WB_RESERVE_BIT] <= 1'b1;
            end
        end
    end

    assign slotTaken = slots[0];

endmodule

// ==== issueSubsystem.f ====
+incdir+test
hdl/issuePkg.sv
hdl/issueQueue.sv
hdl/wbSlotTimer.sv
hdl/mulCtrl.sv
hdl/mulDatapath.sv
hdl/aluWriteback.sv
hdl/issueSubsystem.sv
test/issueTb.sv

// ==== test/issueTbRef.svh ====
`ifndef ISSUE_TB_REF_SVH
`define ISSUE_TB_REF_SVH

// Expected writeback value for one micro-op
function automatic issuePkg::Data refResult(input issuePkg::FuncUnit fu,
        input issuePkg::AluOp op, input issuePkg::Data a, input issuePkg::Data b);
    logic [2*issuePkg::DATA_BITS-1:0] product;
    issuePkg::Data result;
    product = {{issuePkg::DATA_BITS{1'b0}}, a} * {{issuePkg::DATA_BITS{1'b0}}, b};
    if (fu == issuePkg::FU_MUL) begin
        // Low half of the full product
        result = product[issuePkg::DATA_BITS-1:0];
    end else begin
        case (op)
            issuePkg::ADD: result = a + b;
            issuePkg::SUB: result = a - b;
            issuePkg::AND: result = a & b;
            default:       result = a ^ b;
        endcase
    end
    return result;
endfunction

task automatic checkData(input string name, input issuePkg::Data expected,
        input issuePkg::Data actual);
    if (actual !== expected) begin
        dataErrs++;
        $display("ERR %s: expected data %h, actual %h", name, expected, actual);
    end
endtask

task automatic checkTag(input string name, input issuePkg::Tag expected,
        input issuePkg::Tag actual);
    if (actual !== expected) begin
        tagErrs++;
        $display("ERR %s: expected tag %0d, actual %0d", name, expected, actual);
    end
endtask

task automatic checkCount(input string name, input int expected, input int actual);
    if (actual != expected) begin
        countErrs++;
        $display("ERR %s: expected %0d, actual %0d", name, expected, actual);
    end
endtask

`endif

// ==== test/issueTb.sv ====
`timescale 1ns/10ps

module issueTb;

    localparam int TAG_COUNT = 2 ** issuePkg::TAG_BITS;
    localparam issuePkg::Tag EXT_TAG = issuePkg::Tag'(TAG_COUNT - 1);
    // Five tests, about 40 ops each at worst case multiplier spacing, plus margin
    localparam int TIMEOUT_CYCLES = 5 * 40 * issuePkg::MUL_LATENCY + 400;
    // One test of about 40 ops drains well within this
    localparam int DRAIN_CYCLES = 40 * issuePkg::MUL_LATENCY;
    localparam logic [31:0] SEED = 32'hc2e0_de60;

    logic              clk = 1'b0;
    logic              rst;
    logic              dispValid;
    issuePkg::FuncUnit dispFu;
    issuePkg::AluOp    dispOp;
    issuePkg::SqN      dispSqN;
    issuePkg::Tag      dispTagDst;
    issuePkg::Tag      dispTagA;
    issuePkg::Tag      dispTagB;
    logic              dispAvailA;
    logic              dispAvailB;
    issuePkg::Data     dispDataA;
    issuePkg::Data     dispDataB;
    logic              extWakeValid;
    issuePkg::Tag      extWakeTag;
    logic              flushValid;
    issuePkg::SqN      flushSqN;
    logic              full;
    logic              wbValid;
    issuePkg::Tag      wbTag;
    issuePkg::Data     wbData;

    // Scoreboard of dispatched ops, indexed by destination tag
    logic          inFlight [TAG_COUNT];
    logic          doneTag [TAG_COUNT];
    logic          flushedTag [TAG_COUNT];
    logic          hasProd [TAG_COUNT];
    logic          isMul [TAG_COUNT];
    issuePkg::Tag  prodTag [TAG_COUNT];
    issuePkg::Data expData [TAG_COUNT];
    issuePkg::SqN  sqOf [TAG_COUNT];
    int            dispEdge [TAG_COUNT];
    int            issEdge [TAG_COUNT];
    int            wbEdge [TAG_COUNT];
    issuePkg::Tag  chainQ [$];
    issuePkg::Tag  popped;

    int           cycles = 0;
    int           pending = 0;
    int           wbCount = 0;
    int           dataErrs = 0;
    int           tagErrs = 0;
    int           countErrs = 0;
    int           otherErrs = 0;
    string        testName = "reset";
    issuePkg::SqN nextSqN = '0;
    issuePkg::Tag nextTag = '0;

    `include "issueTbRef.svh"

    issueSubsystem i_issueSubsystem (
        .clk(clk),
        .rst(rst),
        .dispValid(dispValid),
        .dispFu(dispFu),
        .dispOp(dispOp),
        .dispSqN(dispSqN),
        .dispTagDst(dispTagDst),
        .dispTagA(dispTagA),
        .dispTagB(dispTagB),
        .dispAvailA(dispAvailA),
        .dispAvailB(dispAvailB),
        .dispDataA(dispDataA),
        .dispDataB(dispDataB),
        .extWakeValid(extWakeValid),
        .extWakeTag(extWakeTag),
        .flushValid(flushValid),
        .flushSqN(flushSqN),
        .full(full),
        .wbValid(wbValid),
        .wbTag(wbTag),
        .wbData(wbData)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
    end

    task automatic clearPulses();
        dispValid = 1'b0;
        extWakeValid = 1'b0;
        flushValid = 1'b0;
    endtask

    task automatic idleCycles(input int n);
        repeat (n) begin
            @(negedge clk);
            clearPulses();
        end
    endtask

    // Bounded so that a lost op shows up in the writeback counts
    task automatic waitDrain();
        int waited;
        waited = 0;
        @(negedge clk);
        clearPulses();
        while (pending > 0 && waited < DRAIN_CYCLES) begin
            @(negedge clk);
            waited++;
        end
    endtask

    // Tag 31 is reserved for the external wake port
    task automatic allocTag(output issuePkg::Tag t);
        int tries;
        tries = 0;
        t = nextTag;
        while ((inFlight[t] || flushedTag[t]) && tries < TAG_COUNT) begin
            t = (t == EXT_TAG - 1) ? '0 : t + 1'b1;
            tries++;
        end
        if (tries == TAG_COUNT) begin
            otherErrs++;
            $display("%s: no free tag left for dispatch", testName);
        end
        nextTag = (t == EXT_TAG - 1) ? '0 : t + 1'b1;
    endtask

    task automatic dispatchOp(input issuePkg::FuncUnit fu, input issuePkg::AluOp op,
            input logic dep, input issuePkg::Tag src, input logic needRoom,
            output issuePkg::Tag dst);
        issuePkg::Data a;
        issuePkg::Data b;
        a = issuePkg::Data'($urandom());
        b = issuePkg::Data'($urandom());
        dst = '0;
        @(negedge clk);
        clearPulses();
        if (needRoom && full) begin
            otherErrs++;
            $display("%s: queue full before a dispatch that should fit", testName);
        end else begin
            while (full) begin
                @(negedge clk);
            end
            allocTag(dst);
            inFlight[dst] = 1'b1;
            doneTag[dst] = 1'b0;
            isMul[dst] = fu == issuePkg::FU_MUL;
            hasProd[dst] = dep && src != EXT_TAG;
            prodTag[dst] = src;
            expData[dst] = refResult(fu, op, a, b);
            sqOf[dst] = nextSqN;
            dispEdge[dst] = cycles;
            pending++;
            dispValid = 1'b1;
            dispFu = fu;
            dispOp = op;
            dispSqN = nextSqN;
            dispTagDst = dst;
            dispTagA = src;
            // Producer already written back means the source is ready
            dispAvailA = !dep || doneTag[src];
            dispTagB = '0;
            dispAvailB = 1'b1;
            dispDataA = a;
            dispDataB = b;
            nextSqN = nextSqN + 1'b1;
        end
    endtask

    task automatic pulseWake(input issuePkg::Tag t);
        @(negedge clk);
        clearPulses();
        extWakeValid = 1'b1;
        extWakeTag = t;
        doneTag[t] = 1'b1;
    endtask

    task automatic pulseFlush(input issuePkg::SqN s);
        @(negedge clk);
        clearPulses();
        flushValid = 1'b1;
        flushSqN = s;
    endtask

    task automatic fillWaiting(input int n);
        issuePkg::Tag dst;
        for (int i = 0; i < n; i++) begin
            dispatchOp(issuePkg::FuncUnit'($urandom_range(1, 0)),
                issuePkg::AluOp'($urandom_range(3, 0)), 1'b1, EXT_TAG, 1'b1, dst);
        end
        @(negedge clk);
        clearPulses();
        if (full !== 1'b1) begin
            otherErrs++;
            $display("%s: full stayed low with %0d ops held", testName, n);
        end
    endtask

    task automatic streamIndependentOps();
        issuePkg::Tag dst;
        issuePkg::Tag first;
        int start;
        testName = "independent alu";
        start = wbCount;
        first = '0;
        for (int i = 0; i < 30; i++) begin
            dispatchOp(issuePkg::FU_ALU, issuePkg::AluOp'($urandom_range(3, 0)),
                1'b0, '0, 1'b0, dst);
            if (i == 0) begin
                first = dst;
            end
        end
        waitDrain();
        checkCount("independent alu count", 30, wbCount - start);
        checkCount("independent alu first latency", 2, wbEdge[first] - dispEdge[first]);
    endtask

    task automatic walkDependencyChain();
        issuePkg::Tag dst;
        issuePkg::Tag prev;
        int start;
        testName = "dependency chain";
        start = wbCount;
        chainQ.delete();
        dispatchOp(issuePkg::FU_ALU, issuePkg::ADD, 1'b0, '0, 1'b0, dst);
        chainQ.push_back(dst);
        prev = dst;
        for (int i = 1; i < 12; i++) begin
            dispatchOp(issuePkg::FU_ALU, issuePkg::AluOp'($urandom_range(3, 0)),
                1'b1, prev, 1'b0, dst);
            chainQ.push_back(dst);
            prev = dst;
        end
        waitDrain();
        checkCount("dependency chain count", 12, wbCount - start);
        checkCount("dependency chain leftover", 0, chainQ.size());
    endtask

    task automatic mixMultiplies();
        issuePkg::Tag dst;
        int start;
        testName = "multiplier mix";
        start = wbCount;
        for (int i = 0; i < 24; i++) begin
            dispatchOp(issuePkg::FuncUnit'($urandom_range(1, 0)),
                issuePkg::AluOp'($urandom_range(3, 0)), 1'b0, '0, 1'b0, dst);
        end
        waitDrain();
        checkCount("multiplier mix count", 24, wbCount - start);
    endtask

    task automatic overfillQueue();
        issuePkg::Tag dst;
        int start;
        testName = "full queue";
        start = wbCount;
        doneTag[EXT_TAG] = 1'b0;
        fillWaiting(issuePkg::IQ_SIZE);
        pulseWake(EXT_TAG);
        dispatchOp(issuePkg::FU_ALU, issuePkg::XOR, 1'b1, EXT_TAG, 1'b0, dst);
        waitDrain();
        checkCount("full queue count", issuePkg::IQ_SIZE + 1, wbCount - start);
    endtask

    task automatic flushYoungerOps();
        issuePkg::Tag held [4];
        int start;
        testName = "flush";
        start = wbCount;
        doneTag[EXT_TAG] = 1'b0;
        for (int i = 0; i < 4; i++) begin
            dispatchOp(issuePkg::FU_ALU, issuePkg::AluOp'($urandom_range(3, 0)),
                1'b1, EXT_TAG, 1'b1, held[i]);
        end
        pulseFlush(sqOf[held[1]]);
        for (int i = 2; i < 4; i++) begin
            inFlight[held[i]] = 1'b0;
            flushedTag[held[i]] = 1'b1;
            pending--;
        end
        pulseWake(EXT_TAG);
        waitDrain();
        // Window for a flushed op to show up late
        idleCycles(2 * issuePkg::MUL_LATENCY);
        checkCount("flush count", 2, wbCount - start);
        doneTag[EXT_TAG] = 1'b0;
        fillWaiting(issuePkg::IQ_SIZE);
        pulseWake(EXT_TAG);
        waitDrain();
        checkCount("flush refill count", 2 + issuePkg::IQ_SIZE, wbCount - start);
    endtask

    // Writeback compare and issue time capture
    always @(posedge clk) begin
        if (!rst && wbValid === 1'b1) begin
            if (!inFlight[wbTag]) begin
                otherErrs++;
                if (flushedTag[wbTag]) begin
                    $display("%s: writeback for flushed tag %0d", testName, wbTag);
                end else if (doneTag[wbTag]) begin
                    $display("%s: second writeback for tag %0d", testName, wbTag);
                end else begin
                    $display("%s: writeback for unknown tag %0d", testName, wbTag);
                end
            end else begin
                checkData(testName, expData[wbTag], wbData);
                if (hasProd[wbTag] && !doneTag[prodTag[wbTag]]) begin
                    otherErrs++;
                    $display("%s: tag %0d wrote back before its producer %0d",
                        testName, wbTag, prodTag[wbTag]);
                end
                if (chainQ.size() > 0) begin
                    popped = chainQ.pop_front();
                    checkTag(testName, popped, wbTag);
                end
                checkCount({testName, " latency"}, isMul[wbTag] ? issuePkg::MUL_LATENCY : 1,
                    cycles - 1 - issEdge[wbTag]);
                wbEdge[wbTag] = cycles - 1;
                inFlight[wbTag] = 1'b0;
                doneTag[wbTag] = 1'b1;
                wbCount++;
                pending--;
            end
        end
        if (!rst && i_issueSubsystem.issValid === 1'b1) begin
            issEdge[i_issueSubsystem.issTag] = cycles - 1;
        end
    end

    initial begin
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
        end
        otherErrs++;
        $display("timeout after %0d cycles with %0d ops still in flight", cycles, pending);
        $display("errors: data %0d, tag %0d, count %0d, other %0d",
            dataErrs, tagErrs, countErrs, otherErrs);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        void'($urandom(SEED));
        rst = 1'b1;
        clearPulses();
        dispFu = issuePkg::FU_ALU;
        dispOp = issuePkg::ADD;
        dispSqN = '0;
        dispTagDst = '0;
        dispTagA = '0;
        dispTagB = '0;
        dispAvailA = 1'b0;
        dispAvailB = 1'b0;
        dispDataA = '0;
        dispDataB = '0;
        extWakeTag = '0;
        flushSqN = '0;
        for (int i = 0; i < TAG_COUNT; i++) begin
            inFlight[i] = 1'b0;
            doneTag[i] = 1'b0;
            flushedTag[i] = 1'b0;
            hasProd[i] = 1'b0;
            isMul[i] = 1'b0;
            issEdge[i] = 0;
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        if (full !== 1'b0 || wbValid !== 1'b0) begin
            otherErrs++;
            $display("full or wbValid not low after reset");
        end
        streamIndependentOps();
        walkDependencyChain();
        mixMultiplies();
        overfillQueue();
        flushYoungerOps();
        idleCycles(4);
        $display("errors: data %0d, tag %0d, count %0d, other %0d",
            dataErrs, tagErrs, countErrs, otherErrs);
        if (dataErrs + tagErrs + countErrs + otherErrs == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
